// File: design/hdc_pkg.sv
package hdc_pkg;

    // hypervector width and number of encoder cores
    localparam int DIM       = 64;
    localparam int NUM_CORES = 8;

    // signed vote counter per bit
    // 15 full batches of 8 votes stay inside +/-127
    localparam int CNT_W = 8;

    // per-batch vote of one bit, -NUM_CORES .. +NUM_CORES
    localparam int VOTE_W = $clog2(NUM_CORES) + 2;

    // stored-vector count of one bundle
    localparam int TOTAL_W = 10;

    // counter limits, an update must stay strictly inside
    localparam logic signed [CNT_W-1:0] CNT_MAX = {1'b0, {(CNT_W-1){1'b1}}};
    localparam logic signed [CNT_W-1:0] CNT_MIN = {1'b1, {(CNT_W-1){1'b0}}};

    // one binary hypervector
    typedef logic [DIM-1:0] hv_t;

    // xorshift start value, any nonzero word works
    localparam hv_t TIE_SEED = 64'h9E37_79B9_7F4A_7C15;

    // one batch strobe from the encoder cores
    typedef struct packed {
        // core c result sits at core_result[c]
        hv_t [NUM_CORES-1:0]  core_result;
        // bit c set means core c votes in this batch
        logic [NUM_CORES-1:0] store;
        // closes the bundle after this batch
        logic                 last;
    } batch_t;

    // one signed vote counter
    typedef logic signed [CNT_W-1:0] cnt_t;

    // all DIM counters side by side, element b belongs to bit b
    typedef cnt_t [DIM-1:0] count_vec_t;

    // tie-break payload for the sign stage
    typedef struct packed {
        // generator state of the closed bundle
        hv_t  vec;
        // stored total of the bundle is even, ties are possible
        logic even;
    } tie_t;

endpackage

// File: design/vote_accumulator.sv
module vote_accumulator (
    input  logic                clk,
    input  logic                rst,
    input  logic                batch_v,
    input  hdc_pkg::batch_t     batch,
    output logic                counts_v,
    output hdc_pkg::count_vec_t counts
);
    import hdc_pkg::*;

    // vote of the current batch per bit
    logic signed [VOTE_W-1:0] delta [DIM];

    // one bit wider than a counter so the limit check sees a wrap
    logic signed [CNT_W:0]    sum_wide [DIM];

    // running counters of the open bundle
    count_vec_t               acc_q;
    count_vec_t               acc_next;

    // some bit would hit the counter limit with this batch
    logic                     at_limit;

    // masked votes, +1 for a one and -1 for a zero
    always_comb begin
        for (int b = 0; b < DIM; b++) begin
            delta[b] = '0;
            for (int c = 0; c < NUM_CORES; c++) begin
                if (batch.store[c]) begin
                    if (batch.core_result[c][b]) begin
                        delta[b] = delta[b] + VOTE_W'(1);
                    end else begin
                        delta[b] = delta[b] - VOTE_W'(1);
                    end
                end
            end
        end
    end

    // running sum including this batch
    always_comb begin
        at_limit = 1'b0;
        for (int b = 0; b < DIM; b++) begin
            sum_wide[b] = acc_q[b] + delta[b];
            acc_next[b] = sum_wide[b][CNT_W-1:0];
            if ((sum_wide[b] >= CNT_MAX) || (sum_wide[b] <= CNT_MIN)) begin
                at_limit = 1'b1;
            end
        end
    end

    // counters restart on the same edge that takes the snapshot,
    // so a batch right after a last one starts from zero
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q    <= '0;
            counts_v <= 1'b0;
        end else begin
            counts_v <= batch_v && batch.last;
            if (batch_v) begin
                if (batch.last) begin
                    acc_q <= '0;
                end else begin
                    acc_q <= acc_next;
                end
            end
        end
    end

    // snapshot of the closed bundle, held until the next close
    always_ff @(posedge clk) begin
        if (batch_v && batch.last) begin
            counts <= acc_next;
        end
    end

    // a bundle longer than the counters allow would corrupt the sign
    no_cnt_limit_a: assert property (
        @(posedge clk) disable iff (rst)
        batch_v |-> !at_limit
    ) else $error("vote counter reached its signed limit");

endmodule

// File: design/tie_break_gen.sv
module tie_break_gen (
    input  logic            clk,
    input  logic            rst,
    input  logic            batch_v,
    input  hdc_pkg::batch_t batch,
    output hdc_pkg::tie_t   tie
);
    import hdc_pkg::*;

    // xorshift state, one step per closed bundle
    hv_t                state_q;

    // stored vectors in the open bundle
    logic [TOTAL_W-1:0] total_q;
    logic [TOTAL_W-1:0] total_next;

    // stored cores of this batch
    logic [TOTAL_W-1:0] stored;

    // 64-bit xorshift, shifts 13, 7, 17
    function automatic hv_t xorshift_step(input hv_t x);
        hv_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    // popcount of the store mask
    always_comb begin
        stored = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            stored = stored + TOTAL_W'(batch.store[c]);
        end
        total_next = total_q + stored;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= TIE_SEED;
            total_q <= '0;
        end else if (batch_v) begin
            if (batch.last) begin
                state_q <= xorshift_step(state_q);
                total_q <= '0;
            end else begin
                total_q <= total_next;
            end
        end
    end

    // published on the same edge as counts_v
    // the vector is the state before the step
    always_ff @(posedge clk) begin
        if (batch_v && batch.last) begin
            tie.vec  <= state_q;
            tie.even <= ~total_next[0];
        end
    end

    // a zero state would lock the generator at zero
    state_nonzero_a: assert property (
        @(posedge clk) disable iff (rst)
        state_q != '0
    ) else $error("tie-break xorshift state is zero");

endmodule

// File: design/bundle_sign.sv
module bundle_sign (
    input  logic                clk,
    input  logic                rst,
    input  logic                counts_v,
    input  hdc_pkg::count_vec_t counts,
    input  hdc_pkg::tie_t       tie,
    output logic                stream_v,
    output hdc_pkg::hv_t        stream_d
);
    import hdc_pkg::*;

    // count plus tie vote, one bit of headroom
    logic signed [CNT_W:0] adj [DIM];

    // extra vote from the tie-break bit, zero for an odd total
    logic signed [1:0]     tie_vote [DIM];

    // majority result before the register
    hv_t                   sign_bit;

    // at least one bit has no majority yet
    logic                  any_zero;

    always_comb begin
        for (int b = 0; b < DIM; b++) begin
            if (!tie.even) begin
                tie_vote[b] = 2'sd0;
            end else if (tie.vec[b]) begin
                tie_vote[b] = 2'sd1;
            end else begin
                tie_vote[b] = -2'sd1;
            end
        end
    end

    // positive sum gives a one, anything else a zero
    always_comb begin
        any_zero = 1'b0;
        for (int b = 0; b < DIM; b++) begin
            adj[b]      = counts[b] + tie_vote[b];
            sign_bit[b] = adj[b] > 0;
            if (counts[b] == '0) begin
                any_zero = 1'b1;
            end
        end
    end

    // result held until the next bundle closes
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_v <= 1'b0;
            stream_d <= '0;
        end else begin
            stream_v <= counts_v;
            if (counts_v) begin
                stream_d <= sign_bit;
            end
        end
    end

    // parity from the generator must agree with the vote counts,
    // an odd number of +/-1 votes never sums to zero
    odd_no_tie_a: assert property (
        @(posedge clk) disable iff (rst)
        (counts_v && !tie.even) |-> !any_zero
    ) else $error("zero vote count in a bundle with odd stored total");

endmodule

// File: design/hdc_bundler.sv
module hdc_bundler (
    input  logic            clk,
    input  logic            rst,
    input  logic            batch_v,
    input  hdc_pkg::batch_t batch,
    output logic            stream_v,
    output hdc_pkg::hv_t    stream_d
);
    import hdc_pkg::*;

    // closed-bundle counts, valid for one cycle
    logic       counts_v;
    count_vec_t counts;

    // tie-break vector and parity, updated with counts_v
    tie_t       tie;

    // per-bit vote counting over the masked cores
    vote_accumulator vote_accumulator_inst (
        .clk      (clk),
        .rst      (rst),
        .batch_v  (batch_v),
        .batch    (batch),
        .counts_v (counts_v),
        .counts   (counts)
    );

    // stored-vector parity and pseudo-random tie vector
    tie_break_gen tie_break_gen_inst (
        .clk     (clk),
        .rst     (rst),
        .batch_v (batch_v),
        .batch   (batch),
        .tie     (tie)
    );

    // final majority, two cycles after the last batch
    bundle_sign bundle_sign_inst (
        .clk      (clk),
        .rst      (rst),
        .counts_v (counts_v),
        .counts   (counts),
        .tie      (tie),
        .stream_v (stream_v),
        .stream_d (stream_d)
    );

endmodule

// File: verif/hdc_bundler_model.svh
`ifndef HDC_BUNDLER_MODEL_SVH
`define HDC_BUNDLER_MODEL_SVH

// running vote sum per hypervector bit, index i is bit i
typedef int vote_sum_t [DIM];

// 64-bit xorshift, shifts 13, 7, 17
function automatic hv_t tie_state_step(input hv_t s);
    hv_t n;
    n = s ^ (s << 13);
    n = n ^ (n >> 7);
    n = n ^ (n << 17);
    return n;
endfunction

// number of stored cores in a mask
function automatic int popcount_mask(input logic [NUM_CORES-1:0] mask);
    int n;
    n = 0;
    for (int c = 0; c < NUM_CORES; c++) begin
        if (mask[c]) begin
            n++;
        end
    end
    return n;
endfunction

// +1 for a one, -1 for a zero, stored cores only
function automatic vote_sum_t add_batch_votes(input vote_sum_t sums, input batch_t b);
    vote_sum_t r;
    r = sums;
    for (int c = 0; c < NUM_CORES; c++) begin
        if (b.store[c]) begin
            for (int i = 0; i < DIM; i++) begin
                r[i] += b.core_result[c][i] ? 1 : -1;
            end
        end
    end
    return r;
endfunction

// sign of the votes, with one tie vote when the stored total is even
function automatic hv_t expected_bundle(input vote_sum_t sums, input int total,
                                        input hv_t tie_vec);
    hv_t r;
    int  v;
    for (int i = 0; i < DIM; i++) begin
        v = sums[i];
        if (total % 2 == 0) begin
            v += tie_vec[i] ? 1 : -1;
        end
        r[i] = (v > 0);
    end
    return r;
endfunction

`endif

// File: verif/hdc_bundler_tb.sv
module hdc_bundler_tb;
    import hdc_pkg::*;

    `include "hdc_bundler_model.svh"

    localparam int NUM_RANDOM_BUNDLES = 60;
    localparam int DRAIN_TIMEOUT      = 40;

    logic        clk;
    logic        rst;
    logic        batch_v;
    batch_t      batch;
    logic        stream_v;
    hv_t         stream_d;
    logic        last_strobe;

    // stimulus generator state
    logic [63:0] rng_state;

    // model of the open bundle
    vote_sum_t   vote_sum;
    int          stored_total;
    hv_t         model_tie;

    // scoreboard
    hv_t         exp_q [$];
    hv_t         exp_head;
    int          exp_pending;
    int          bundles_sent;
    int          results_seen;
    int          closes_since_rst;

    hdc_bundler hdc_bundler_inst (
        .clk      (clk),
        .rst      (rst),
        .batch_v  (batch_v),
        .batch    (batch),
        .stream_v (stream_v),
        .stream_d (stream_d)
    );

    assign last_strobe = batch_v && batch.last;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped on a timeout");
    endtask

    stream_after_last_a: assert property (
        @(posedge clk) disable iff (rst)
        last_strobe |-> ##2 stream_v
    ) else report_mismatch("stream_v missing two cycles after a last batch");

    stream_only_after_last_a: assert property (
        @(posedge clk) disable iff (rst)
        stream_v |-> $past(last_strobe, 2)
    ) else report_mismatch("stream_v without a last batch two cycles before");

    stream_data_a: assert property (
        @(posedge clk) disable iff (rst)
        stream_v |-> (exp_pending > 0) && (stream_d == exp_head)
    ) else report_mismatch($sformatf("stream_d %h, expected %h",
                                     $sampled(stream_d), $sampled(exp_head)));

    // nothing leaves the unit before the first close after a reset
    idle_after_reset_a: assert property (
        @(posedge clk) disable iff (rst)
        (closes_since_rst == 0) |-> !stream_v && (stream_d == '0)
    ) else report_mismatch("output active before the first bundle closed");

    function automatic void refresh_head();
        exp_pending = exp_q.size();
        if (exp_pending > 0) begin
            exp_head = exp_q[0];
        end else begin
            exp_head = '0;
        end
    endfunction

    // retire the head on each result pulse
    always @(posedge clk) begin
        if (!rst && stream_v && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            results_seen++;
            refresh_head();
        end
    end

    function automatic logic [63:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic void reset_model();
        foreach (vote_sum[i]) begin
            vote_sum[i] = 0;
        end
        stored_total     = 0;
        model_tie        = TIE_SEED;
        closes_since_rst = 0;
        exp_q.delete();
        refresh_head();
    endfunction

    function automatic batch_t random_batch(input logic last);
        batch_t      b;
        logic [63:0] r;
        for (int c = 0; c < NUM_CORES; c++) begin
            b.core_result[c] = next_random();
        end
        r       = next_random();
        b.store = r[NUM_CORES-1:0];
        b.last  = last;
        return b;
    endfunction

    // seven stored cores, odd total
    function automatic batch_t odd_batch();
        batch_t b;
        b       = random_batch(1'b1);
        b.store = 8'h7F;
        return b;
    endfunction

    // cores 4..7 carry the inverse of cores 0..3 so every bit ties
    function automatic batch_t tie_batch();
        batch_t b;
        hv_t    r;
        for (int c = 0; c < NUM_CORES / 2; c++) begin
            r                               = next_random();
            b.core_result[c]                = r;
            b.core_result[c + NUM_CORES/2]  = ~r;
        end
        b.store = '1;
        b.last  = 1'b1;
        return b;
    endfunction

    task automatic drive_batch(input batch_t b);
        @(posedge clk);
        #1;
        batch_v      = 1'b1;
        batch        = b;
        vote_sum     = add_batch_votes(vote_sum, b);
        stored_total += popcount_mask(b.store);
        if (b.last) begin
            exp_q.push_back(expected_bundle(vote_sum, stored_total, model_tie));
            refresh_head();
            model_tie = tie_state_step(model_tie);
            foreach (vote_sum[i]) begin
                vote_sum[i] = 0;
            end
            stored_total = 0;
            bundles_sent++;
            closes_since_rst++;
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        batch_v = 1'b0;
        batch   = '0;
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #1;
        rst     = 1'b1;
        batch_v = 1'b0;
        batch   = '0;
        repeat (cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_model();
    endtask

    task automatic random_bundle();
        int n_batches;
        n_batches = 1 + int'(next_random() % 4);
        for (int i = 0; i < n_batches; i++) begin
            drive_batch(random_batch(i == n_batches - 1));
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_pending != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_pending != 0) begin
            abort_on_timeout("the pending bundle results");
        end
    endtask

    initial begin
        int gap;
        rng_state    = 64'd1;
        rst          = 1'b1;
        batch_v      = 1'b0;
        batch        = '0;
        bundles_sent = 0;
        results_seen = 0;
        reset_model();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (5) drive_idle();

        // single batch, odd count, then full ties back to back
        drive_batch(odd_batch());
        drive_idle();
        drive_batch(tie_batch());
        drive_batch(tie_batch());
        drive_batch(odd_batch());
        drive_idle();
        wait_drained();

        // partial bundle thrown away, tie state back at the seed
        drive_batch(random_batch(1'b0));
        drive_batch(random_batch(1'b0));
        apply_reset(3);
        repeat (3) drive_idle();
        drive_batch(tie_batch());
        drive_idle();
        wait_drained();

        // mixed masks, 1 to 4 batches, gaps of 0 to 2 cycles
        for (int k = 0; k < NUM_RANDOM_BUNDLES; k++) begin
            random_bundle();
            gap = int'(next_random() % 3);
            repeat (gap) drive_idle();
        end
        drive_idle();
        wait_drained();

        if (results_seen == bundles_sent && exp_pending == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_mismatch($sformatf("%0d results seen for %0d bundles",
                                      results_seen, bundles_sent));
        end
    end

endmodule

// File: vlog.f
+incdir+verif
design/hdc_pkg.sv
design/vote_accumulator.sv
design/tie_break_gen.sv
design/bundle_sign.sv
design/hdc_bundler.sv
verif/hdc_bundler_tb.sv

// File: Bender.yml
package:
  name: hdc_bundler

sources:
  - files:
      - design/hdc_pkg.sv
      - design/vote_accumulator.sv
      - design/tie_break_gen.sv
      - design/bundle_sign.sv
      - design/hdc_bundler.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/hdc_bundler_tb.sv
